// ==== isaPkg.sv ====
package isaPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    // major opcodes the core understands
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011, // lw
        OP_STORE  = 7'b0100011, // sw
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011, // beq only
        OP_JAL    = 7'b1101111
    } opcode_t;

    localparam word_t RESET_PC = '0;

    // request toward the data memory, answered in the same cycle
    typedef struct packed {
        word_t address;
        word_t writeData;
        logic  write;     // commits at the next rising clk
    } dmemReq_t;

endpackage

// ==== ctrlPkg.sv ====
package ctrlPkg;

    // immediate format select
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } immSrc_t;

    // write-back source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } resultSrc_t;

    // class of ALU operation handed to the ALU decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00, // address calculation
        ALUOP_SUB   = 2'b01, // beq compare
        ALUOP_FUNCT = 2'b10  // look at funct3 / funct7
    } aluOp_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } aluCtrl_t;

    typedef struct packed {
        logic       regWrite;
        immSrc_t    immSrc;
        logic       aluSrc;    // 1 selects the immediate as operand b
        logic       memWrite;
        resultSrc_t resultSrc;
        logic       branch;
        logic       jump;
        aluOp_t     aluOp;
    } ctrlSignals_t;

endpackage

// ==== mainDecoder.sv ====
module mainDecoder (
    input  isaPkg::opcode_t       op,
    output ctrlPkg::ctrlSignals_t ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // no-op bundle unless the opcode is recognised
        ctrl = '{regWrite: 1'b0, immSrc: IMM_I, aluSrc: 1'b0, memWrite: 1'b0,
                 resultSrc: RES_ALU, branch: 1'b0, jump: 1'b0, aluOp: ALUOP_ADD};
        case (op)
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_MEM;
            end
            OP_STORE: begin
                ctrl.immSrc   = IMM_S;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT;
            end
            OP_BRANCH: begin
                ctrl.immSrc = IMM_B;
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALUOP_SUB; // equality via zero flag
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT;
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC4; // link address
                ctrl.jump      = 1'b1;
                ctrl.aluOp     = ALUOP_FUNCT; // unused for jal
            end
            default: begin
                // unsupported opcode, keep the no-op bundle
            end
        endcase
    end

    // a store never also writes back
    always_comb begin
        assert final (!(ctrl.memWrite && ctrl.regWrite))
            else $error("mainDecoder: memWrite and regWrite both high for op %b", op);
    end

endmodule

// ==== aluDecoder.sv ====
module aluDecoder (
    input  ctrlPkg::aluOp_t   aluOp,
    input  logic [2:0]        funct3,
    input  logic              funct7b5,
    input  logic              opb5,     // set for register-register ops
    output ctrlPkg::aluCtrl_t aluCtrl
);
    import ctrlPkg::*;

    logic isSub;

    // only R-type with funct7[5] set means sub, addi never does
    assign isSub = opb5 & funct7b5;

    always_comb begin
        case (aluOp)
            ALUOP_ADD: aluCtrl = ALU_ADD;
            ALUOP_SUB: aluCtrl = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct3)
                    3'b000:  aluCtrl = isSub ? ALU_SUB : ALU_ADD;
                    3'b010:  aluCtrl = ALU_SLT;
                    3'b110:  aluCtrl = ALU_OR;
                    3'b111:  aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD; // unsupported funct3
                endcase
            end
            default: aluCtrl = ALU_ADD;
        endcase
    end

endmodule

// ==== controller.sv ====
module controller (
    input  isaPkg::word_t         instr,
    input  logic                  zero,
    output ctrlPkg::ctrlSignals_t ctrl,
    output ctrlPkg::aluCtrl_t     aluCtrl,
    output logic                  pcSrc
);
    import isaPkg::*;

    opcode_t op;

    assign op = opcode_t'(instr[6:0]);

    mainDecoder mainDecoder_i (
        .op   (op),
        .ctrl (ctrl)
    );

    aluDecoder aluDecoder_i (
        .aluOp    (ctrl.aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .opb5     (instr[5]),
        .aluCtrl  (aluCtrl)
    );

    assign pcSrc = ctrl.jump | (ctrl.branch & zero); // taken beq or jal

    always_comb begin
        assert final (!(ctrl.branch && ctrl.jump))
            else $error("controller: branch and jump both set, instr %h", instr);
    end

endmodule

// ==== immExtend.sv ====
module immExtend (
    input  isaPkg::word_t    instr,
    input  ctrlPkg::immSrc_t immSrc,
    output isaPkg::word_t    immExt
);
    import ctrlPkg::*;

    always_comb begin
        case (immSrc)
            IMM_I: immExt = {{20{instr[31]}}, instr[31:20]};
            IMM_S: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset, always even
            IMM_B: immExt = {{20{instr[31]}}, instr[7], instr[30:25],
                             instr[11:8], 1'b0};
            default: begin
                // jal offset
                immExt = {{12{instr[31]}}, instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            end
        endcase
    end

endmodule

// ==== alu.sv ====
module alu (
    input  isaPkg::word_t     a,
    input  isaPkg::word_t     b,
    input  ctrlPkg::aluCtrl_t aluCtrl,
    output isaPkg::word_t     result,
    output logic              zero
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluCtrl)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lessThan};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0); // beq uses this after a subtract

endmodule

// ==== regFile.sv ====
module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  isaPkg::regAddr_t ra1,
    input  isaPkg::regAddr_t ra2,
    input  isaPkg::regAddr_t wa,
    input  logic             we,
    input  isaPkg::word_t    wd,
    output isaPkg::word_t    rd1,
    output isaPkg::word_t    rd2
);
    import isaPkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rstN && we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // combinational reads
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== dataPath.sv ====
module dataPath (
    input  logic                  clk,
    input  logic                  rstN,
    input  ctrlPkg::ctrlSignals_t ctrl,
    input  ctrlPkg::aluCtrl_t     aluCtrl,
    input  logic                  pcSrc,
    input  isaPkg::word_t         instr,
    input  isaPkg::word_t         readData,
    output isaPkg::word_t         pc,
    output logic                  zero,
    output isaPkg::dmemReq_t      dmemReq
);
    import isaPkg::*;
    import ctrlPkg::*;

    word_t pcPlus4;
    word_t pcTarget;
    word_t pcNext;
    word_t immExt;
    word_t rd1;
    word_t rd2;
    word_t srcB;
    word_t aluResult;
    word_t result;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt; // beq and jal both pc-relative
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    regFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .ra1  (instr[19:15]),
        .ra2  (instr[24:20]),
        .wa   (instr[11:7]),
        .we   (ctrl.regWrite),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    immExtend immExtend_i (
        .instr  (instr),
        .immSrc (ctrl.immSrc),
        .immExt (immExt)
    );

    assign srcB = ctrl.aluSrc ? immExt : rd2;

    alu alu_i (
        .a       (rd1),
        .b       (srcB),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM: result = readData;
            RES_PC4: result = pcPlus4; // jal link
            default: result = aluResult;
        endcase
    end

    assign dmemReq.address   = aluResult;
    assign dmemReq.writeData = rd2;
    assign dmemReq.write     = ctrl.memWrite & rstN; // no stores while in reset

    // branch and jump offsets are even, targets must still land on words
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("dataPath: pc %h not word aligned", pc);

endmodule

// ==== riscvCore.sv ====
module riscvCore (
    input  logic             clk,
    input  logic             rstN,
    input  isaPkg::word_t    instr,
    input  isaPkg::word_t    readData,
    output isaPkg::word_t    pc,
    output isaPkg::dmemReq_t dmemReq
);
    import ctrlPkg::*;

    ctrlSignals_t ctrl;
    aluCtrl_t     aluCtrl;
    logic         pcSrc;
    logic         zero;

    controller controller_i (
        .instr   (instr),
        .zero    (zero),
        .ctrl    (ctrl),
        .aluCtrl (aluCtrl),
        .pcSrc   (pcSrc)
    );

    dataPath dataPath_i (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .aluCtrl  (aluCtrl),
        .pcSrc    (pcSrc),
        .instr    (instr),
        .readData (readData),
        .pc       (pc),
        .zero     (zero),
        .dmemReq  (dmemReq)
    );

endmodule

// ==== riscvCore_tb.sv ====
module riscvCore_tb;
    import isaPkg::*;

    localparam int    RESET_CYCLES = 4;
    localparam int    PROG_LEN     = 64;
    localparam int    CYCLE_LIMIT  = RESET_CYCLES + PROG_LEN + 32;
    localparam word_t NOP          = 32'h0000_0013; // addi x0, x0, 0

    logic     clk;
    logic     rstN;
    word_t    instr;
    word_t    readData;
    word_t    pc;
    dmemReq_t dmemReq;

    word_t  imem     [0:PROG_LEN-1];
    word_t  dmem     [0:255];   // byte addresses 0x000 to 0x3fc
    word_t  refMem   [0:255];   // model's own copy of data memory
    word_t  refRegs  [0:31];
    logic   refKnown [0:31];    // written since reset
    word_t  refPc;
    integer seed          = 32'h76e5;
    logic   done          = 1'b0;
    int     resetEdges    = 0;
    int     stepCount     = 0;
    int     checkErrors   = 0;
    int     otherErrors   = 0;
    int     timeoutErrors = 0;

    riscvCore riscvCore_i (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .readData (readData),
        .pc       (pc),
        .dmemReq  (dmemReq)
    );

    always #50 clk = ~clk;

    function automatic int randomBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // initial memory contents that vary with every address bit
    function automatic word_t fillWord(word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                   regAddr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encB(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t encJ(logic [20:0] imm, regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // kinds 0..4 are add sub and or slt and 5..9 are addi addi andi ori slti
    function automatic word_t aluInstr(int kind, regAddr_t rd, regAddr_t rs1, regAddr_t rs2,
                                       logic [11:0] imm);
        logic [2:0] f3;
        case (kind % 5)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            default: f3 = 3'b010;
        endcase
        if (kind < 5) begin
            return {(kind == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic buildProgram();
        int       i;
        int       kind;
        regAddr_t rs1;
        regAddr_t rs2;
        word_t    r;
        for (i = 1; i <= 6; i++) begin
            r = $random(seed);
            imem[i-1] = encI(r[11:0] | 12'h001, 5'd0, 3'b000, 5'(i), 7'b0010011); // nonzero
        end
        // each op writes a fresh register from x7 up
        for (i = 0; i < 14; i++) begin
            r    = $random(seed);
            kind = (i < 10) ? i : randomBelow(10); // every kind at least once
            rs1  = 5'(1 + randomBelow(6 + i));
            rs2  = 5'(1 + randomBelow(6 + i));
            imem[6+i] = aluInstr(kind, 5'(7 + i), rs1, rs2, r[11:0]);
        end
        // sw then lw of the same word in the window 0x100..0x13c
        for (i = 0; i < 2; i++) begin
            r   = 32'h100 + 32'(4 * randomBelow(16));
            rs2 = 5'(1 + randomBelow(20));
            imem[20+2*i] = encS(r[11:0], rs2, 5'd0);
            imem[21+2*i] = encI(r[11:0], 5'd0, 3'b010, 5'(21 + i), 7'b0000011);
        end
        imem[24] = encB(13'd8, 5'd0, 5'd0);   // equal operands so taken
        imem[25] = encS(12'h140, 5'd1, 5'd0); // skipped
        imem[26] = encB(13'd8, 5'd0, 5'd1);   // x1 is nonzero so falls through
        r = $random(seed);
        imem[27] = encI(r[11:0], 5'd0, 3'b000, 5'd23, 7'b0010011);
        imem[28] = encJ(21'd8, 5'd24);
        imem[29] = encS(12'h144, 5'd2, 5'd0); // jumped over
        // lui and jalr are not implemented here
        r = $random(seed);
        imem[30] = {r[31:12], 5'd3, 7'b0110111};
        r = $random(seed);
        imem[31] = {r[31:12], 5'd4, 7'b1100111};
        for (i = 1; i <= 31; i++) begin
            imem[31+i] = encS(12'(32'h200 + 32'(4 * i)), 5'(i), 5'd0); // register dump
        end
        imem[63] = encJ(21'd0, 5'd0);
    endtask

    // one instruction of the ISA on the model state
    function automatic void refStep(input word_t curPc, output word_t nextPc,
                                    output dmemReq_t expStore, output logic dataKnown);
        word_t    w;
        word_t    a;
        word_t    b;
        word_t    addr;
        word_t    res;
        logic     wr;
        regAddr_t rd;
        w         = imem[curPc[7:2]];
        rd        = w[11:7];
        a         = refRegs[w[19:15]];
        b         = refRegs[w[24:20]];
        nextPc    = curPc + 32'd4;
        expStore  = '0;
        dataKnown = 1'b1;
        wr        = 1'b0;
        res       = '0;
        case (w[6:0])
            OP_REG, OP_IMM: begin
                if (w[6:0] == OP_IMM) begin
                    b = {{20{w[31]}}, w[31:20]};
                end
                case (w[14:12])
                    3'b000:  res = (w[6:0] == OP_REG && w[30]) ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: res = a + b;
                endcase
                wr = 1'b1;
            end
            OP_LOAD: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                res  = refMem[addr[9:2]];
                wr   = 1'b1;
            end
            OP_STORE: begin
                addr      = a + {{20{w[31]}}, w[31:25], w[11:7]};
                expStore  = '{address: addr, writeData: b, write: 1'b1};
                dataKnown = refKnown[w[24:20]];
                refMem[addr[9:2]] = b;
            end
            OP_BRANCH: begin
                if (a == b) begin
                    nextPc = curPc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            OP_JAL: begin
                res    = curPc + 32'd4;
                wr     = 1'b1;
                nextPc = curPc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ; // unknown opcode is a no-op
        endcase
        if (wr && rd != 5'd0) begin
            refRegs[rd]  = res;
            refKnown[rd] = 1'b1;
        end
    endfunction

    task automatic checkPc(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            checkErrors++;
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkStore(input string name, input dmemReq_t expected,
                              input dmemReq_t actual);
        if (actual !== expected) begin
            checkErrors++;
            $display("CHECK FAILED %s: expected addr %h data %h write %b", name,
                     expected.address, expected.writeData, expected.write);
            $display("    actual addr %h data %h write %b",
                     actual.address, actual.writeData, actual.write);
        end
    endtask

    task automatic finishRun();
        $display("errors: %0d check, %0d other, %0d timeout",
                 checkErrors, otherErrors, timeoutErrors);
        if (checkErrors + otherErrors + timeoutErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // instruction and data memories
    always @(negedge clk) begin
        if (resetEdges < RESET_CYCLES) begin
            instr = encS(12'h148, 5'd0, 5'd0); // store that reset must hold off
        end else begin
            instr = imem[pc[7:2]];
        end
        #10;
        readData = dmem[dmemReq.address[9:2]]; // address settles after instr
    end

    always @(posedge clk) begin
        if (dmemReq.write) begin
            dmem[dmemReq.address[9:2]] <= dmemReq.writeData;
            $display("store %h <- %h", dmemReq.address, dmemReq.writeData);
        end
    end

    always @(posedge clk) begin : compareStep
        word_t    nextPc;
        dmemReq_t expStore;
        dmemReq_t actStore;
        logic     dataKnown;
        if (!rstN) begin
            resetEdges++;
            if (resetEdges > 1) begin
                checkPc("pc in reset", RESET_PC, pc);
            end
            if (dmemReq.write !== 1'b0) begin
                otherErrors++;
                $display("ERROR: data memory write requested while reset is asserted");
            end
        end else if (!done) begin
            checkPc($sformatf("pc of step %0d", stepCount), refPc, pc);
            refStep(refPc, nextPc, expStore, dataKnown);
            actStore = dmemReq;
            if (expStore.write && dmemReq.write) begin
                if (!dataKnown) begin
                    // register never written so its content is undefined
                    expStore.writeData = '0;
                    actStore.writeData = '0;
                end
                checkStore($sformatf("store at pc %h", refPc), expStore, actStore);
            end else if (dmemReq.write) begin
                otherErrors++;
                $display("ERROR: unexpected store to %h at pc %h", dmemReq.address, refPc);
            end else if (expStore.write) begin
                otherErrors++;
                $display("ERROR: store to %h at pc %h never came", expStore.address, refPc);
            end
            if (nextPc == refPc) begin
                done = 1'b1; // jal to itself
            end
            refPc = nextPc;
            stepCount++;
        end
    end

    initial begin : watchdog
        int cycle;
        for (cycle = 0; cycle < CYCLE_LIMIT; cycle++) begin
            @(posedge clk);
        end
        timeoutErrors++;
        $display("ERROR: program did not reach its final jump within %0d cycles", CYCLE_LIMIT);
        finishRun();
    end

    initial begin : mainFlow
        int i;
        clk      = 1'b0;
        rstN     = 1'b0;
        instr    = NOP;
        readData = '0;
        refPc    = RESET_PC;
        for (i = 0; i < 32; i++) begin
            refRegs[i]  = '0;
            refKnown[i] = (i == 0);
        end
        for (i = 0; i < 256; i++) begin
            dmem[i]   = fillWord(32'(i * 4));
            refMem[i] = fillWord(32'(i * 4));
        end
        buildProgram();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        wait (done);
        finishRun();
    end

endmodule

// ==== riscvCore.f ====
isaPkg.sv
ctrlPkg.sv
mainDecoder.sv
aluDecoder.sv
controller.sv
immExtend.sv
alu.sv
regFile.sv
dataPath.sv
riscvCore.sv
riscvCore_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the riscvCore testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module riscvCore_tb -f riscvCore.f -o riscvCore_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/riscvCore_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
